// File: include/mrd_consts.svh
`ifndef MRD_CONSTS_SVH
`define MRD_CONSTS_SVH

// Q1.17 sample width
`define MRD_DW 18
// Q4.17 butterfly result width
`define MRD_AW 21
// complex lanes in one vector
`define MRD_LANES 5
// cycles from engine input to registered engine output
`define MRD_ENG_LAT 6
// fraction bits of the radix-5 coefficients
`define MRD_CF 16

// radix-5 twiddle constants in Q1.16
`define MRD_C1 (18'sd20252)
`define MRD_C2 (-18'sd53020)
`define MRD_S1 (18'sd62328)
`define MRD_S2 (18'sd38521)

`endif

// File: src/mrd_data_pkg.sv
`include "mrd_consts.svh"

package mrd_data_pkg;

	// real or imaginary part of one sample in Q1.17
	typedef logic signed [`MRD_DW-1:0] sample_t;

	// first add level in Q2.17
	typedef logic signed [`MRD_DW:0] sum_t;

	// butterfly result before scaling in Q4.17
	typedef logic signed [`MRD_AW-1:0] acc_t;

	// lanes 0 to 3 packed into one word for the radix-4 input delay
	typedef sample_t [3:0] quad_t;

endpackage

// File: src/mrd_cfg_pkg.sv
package mrd_cfg_pkg;

	// butterfly factor of the stage
	typedef enum logic [2:0] {
		RADIX_2 = 3'd2,
		RADIX_4 = 3'd4,
		RADIX_5 = 3'd5
	} radix_e;

	// bits of headroom the input already carries
	typedef logic [1:0] margin_t;

	// right shift applied to the butterfly results
	typedef logic [1:0] growth_t;

	// block exponent that travels with each vector and wraps at 16
	typedef logic [3:0] exp_t;

endpackage

// File: src/mrd_align_delay.sv
`timescale 1ns/1ps

module mrd_align_delay #(
	parameter type T = logic,
	parameter int DEPTH = 1
) (
	input logic clk,
	input logic rst_n,
	input T d_i,
	output T q_o
);

	T stage_q [DEPTH];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				stage_q[i] <= '0;
			end
		end else begin
			stage_q[0] <= d_i;
			for (int i = 1; i < DEPTH; i++) begin
				stage_q[i] <= stage_q[i-1];
			end
		end
	end

	assign q_o = stage_q[DEPTH-1];

endmodule

// File: src/mrd_bfp_round.sv
`timescale 1ns/1ps
`include "mrd_consts.svh"

module mrd_bfp_round (
	input logic clk,
	input logic rst_n,
	input mrd_data_pkg::acc_t x_i,
	input mrd_cfg_pkg::growth_t growth_i,
	output mrd_data_pkg::sample_t y_o
);

	logic signed [`MRD_AW:0] half;
	logic signed [`MRD_AW:0] biased;
	logic signed [`MRD_AW:0] shifted;

	// half of the last bit shifted out, nothing when there is no shift
	always_comb begin
		half = '0;
		if (growth_i != 2'd0) begin
			half[growth_i - 2'd1] = 1'b1;
		end
		biased = x_i + half;
		shifted = biased >>> growth_i;
	end

	// back to Q1.17
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			y_o <= '0;
		end else begin
			y_o <= shifted[`MRD_DW-1:0];
		end
	end

endmodule

// File: src/mrd_stage_cfg.sv
`timescale 1ns/1ps

module mrd_stage_cfg (
	input logic clk,
	input logic rst_n,
	input logic cfg_we_i,
	input mrd_cfg_pkg::radix_e factor_i,
	input mrd_cfg_pkg::margin_t margin_i,
	output mrd_cfg_pkg::radix_e radix_o,
	output mrd_cfg_pkg::growth_t word_growth_o
);
	import mrd_cfg_pkg::*;

	margin_t margin_q;
	growth_t worst_growth;

	// default stage is radix-4 without headroom
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			radix_o <= RADIX_4;
			margin_q <= '0;
		end else if (cfg_we_i) begin
			radix_o <= factor_i;
			margin_q <= margin_i;
		end
	end

	// radix-2 may grow by 2 bits and the other factors by 3
	always_comb begin
		if (radix_o == RADIX_2) begin
			worst_growth = 2'd2;
		end else begin
			worst_growth = 2'd3;
		end
	end

	// headroom already in the input absorbs part of the growth
	assign word_growth_o = (worst_growth > margin_q) ? worst_growth - margin_q : 2'd0;

endmodule

// File: src/mrd_rdx4_2.sv
`timescale 1ns/1ps
`include "mrd_consts.svh"

module mrd_rdx4_2 (
	input logic clk,
	input logic rst_n,
	input mrd_cfg_pkg::radix_e radix_i,
	input mrd_cfg_pkg::growth_t word_growth_i,
	input mrd_data_pkg::sample_t din_re_i [0:`MRD_LANES-1],
	input mrd_data_pkg::sample_t din_im_i [0:`MRD_LANES-1],
	output mrd_data_pkg::sample_t dout_re_o [0:`MRD_LANES-1],
	output mrd_data_pkg::sample_t dout_im_o [0:`MRD_LANES-1]
);
	import mrd_data_pkg::*;
	import mrd_cfg_pkg::*;

	logic pair_mode;
	quad_t din_re_pk;
	quad_t din_im_pk;
	quad_t sync_re;
	quad_t sync_im;
	sample_t p1_re [0:3];
	sample_t p1_im [0:3];
	sum_t p2_re [0:3];
	sum_t p2_im [0:3];
	acc_t p3_re [0:3];
	acc_t p3_im [0:3];

	// two separate butterflies on lanes 0/1 and 2/3
	assign pair_mode = (radix_i == RADIX_2);

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			din_re_pk[i] = din_re_i[i];
			din_im_pk[i] = din_im_i[i];
		end
	end

	// idle input stages to match the radix-5 engine latency
	mrd_align_delay #(.T(quad_t), .DEPTH(`MRD_ENG_LAT - 4)) sync_re_i (
		.clk, .rst_n, .d_i(din_re_pk), .q_o(sync_re)
	);
	mrd_align_delay #(.T(quad_t), .DEPTH(`MRD_ENG_LAT - 4)) sync_im_i (
		.clk, .rst_n, .d_i(din_im_pk), .q_o(sync_im)
	);

	// radix-4 swaps lanes 1 and 2 so the first level forms x0 +- x2 and x1 +- x3
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			p1_re <= '{default: '0};
			p1_im <= '{default: '0};
		end else begin
			p1_re[0] <= sync_re[0];
			p1_im[0] <= sync_im[0];
			p1_re[1] <= pair_mode ? sync_re[1] : sync_re[2];
			p1_im[1] <= pair_mode ? sync_im[1] : sync_im[2];
			p1_re[2] <= pair_mode ? sync_re[2] : sync_re[1];
			p1_im[2] <= pair_mode ? sync_im[2] : sync_im[1];
			p1_re[3] <= sync_re[3];
			p1_im[3] <= sync_im[3];
		end
	end

	// first add level
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			p2_re <= '{default: '0};
			p2_im <= '{default: '0};
		end else begin
			for (int k = 0; k < 4; k += 2) begin
				p2_re[k] <= p1_re[k] + p1_re[k+1];
				p2_im[k] <= p1_im[k] + p1_im[k+1];
				p2_re[k+1] <= p1_re[k] - p1_re[k+1];
				p2_im[k+1] <= p1_im[k] - p1_im[k+1];
			end
		end
	end

	// second level with the -j rotation of s3 for the forward transform
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			p3_re <= '{default: '0};
			p3_im <= '{default: '0};
		end else if (pair_mode) begin
			for (int k = 0; k < 4; k++) begin
				p3_re[k] <= p2_re[k];
				p3_im[k] <= p2_im[k];
			end
		end else begin
			p3_re[0] <= p2_re[0] + p2_re[2];
			p3_im[0] <= p2_im[0] + p2_im[2];
			p3_re[1] <= p2_re[1] + p2_im[3];
			p3_im[1] <= p2_im[1] - p2_re[3];
			p3_re[2] <= p2_re[0] - p2_re[2];
			p3_im[2] <= p2_im[0] - p2_im[2];
			p3_re[3] <= p2_re[1] - p2_im[3];
			p3_im[3] <= p2_im[1] + p2_re[3];
		end
	end

	for (genvar n = 0; n < 4; n++) begin : g_round
		mrd_bfp_round round_re_i (.clk, .rst_n, .x_i(p3_re[n]), .growth_i(word_growth_i),
			.y_o(dout_re_o[n]));
		mrd_bfp_round round_im_i (.clk, .rst_n, .x_i(p3_im[n]), .growth_i(word_growth_i),
			.y_o(dout_im_o[n]));
	end

	// no fifth point in this engine
	assign dout_re_o[`MRD_LANES-1] = '0;
	assign dout_im_o[`MRD_LANES-1] = '0;

endmodule

// File: src/mrd_rdx5.sv
`timescale 1ns/1ps
`include "mrd_consts.svh"

module mrd_rdx5 (
	input logic clk,
	input logic rst_n,
	input mrd_cfg_pkg::radix_e radix_i,
	input mrd_cfg_pkg::growth_t word_growth_i,
	input mrd_data_pkg::sample_t din_re_i [0:`MRD_LANES-1],
	input mrd_data_pkg::sample_t din_im_i [0:`MRD_LANES-1],
	output mrd_data_pkg::sample_t dout_re_o [0:`MRD_LANES-1],
	output mrd_data_pkg::sample_t dout_im_o [0:`MRD_LANES-1]
);
	import mrd_data_pkg::*;
	import mrd_cfg_pkg::*;

	// real and imaginary slots of the internal pairs
	localparam int RE = 0;
	localparam int IM = 1;

	// Q2.17 times Q1.16 rounded back to Q4.17
	function automatic acc_t mul_rnd(input sum_t a, input sample_t c);
		logic signed [2*`MRD_DW:0] p;
		p = a * c;
		p = p + (1 <<< (`MRD_CF - 1));
		return p[2*`MRD_DW -: `MRD_AW];
	endfunction

	sample_t x_q [0:`MRD_LANES-1][2];
	sample_t x0_s1 [2];
	sample_t x0_s2 [2];
	sample_t x0_s3 [2];
	sum_t a1 [2];
	sum_t b1 [2];
	sum_t a2 [2];
	sum_t b2 [2];
	acc_t t0 [2];
	acc_t m_a1c1 [2];
	acc_t m_a2c2 [2];
	acc_t m_a1c2 [2];
	acc_t m_a2c1 [2];
	acc_t m_b1s1 [2];
	acc_t m_b2s2 [2];
	acc_t m_b1s2 [2];
	acc_t m_b2s1 [2];
	acc_t y0 [2];
	acc_t t1 [2];
	acc_t t2 [2];
	acc_t u1 [2];
	acc_t u2 [2];
	acc_t sum_re [0:`MRD_LANES-1];
	acc_t sum_im [0:`MRD_LANES-1];

	// inputs held at zero outside radix-5 mode to keep the multipliers quiet
	always_ff @(posedge clk) begin
		if (!rst_n || radix_i != RADIX_5) begin
			x_q <= '{default: '0};
		end else begin
			for (int n = 0; n < `MRD_LANES; n++) begin
				x_q[n][RE] <= din_re_i[n];
				x_q[n][IM] <= din_im_i[n];
			end
		end
	end

	// symmetric pre-adds, then constant products, then post-adds
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			x0_s1 <= '{default: '0};
			x0_s2 <= '{default: '0};
			x0_s3 <= '{default: '0};
			a1 <= '{default: '0};
			b1 <= '{default: '0};
			a2 <= '{default: '0};
			b2 <= '{default: '0};
			t0 <= '{default: '0};
			m_a1c1 <= '{default: '0};
			m_a2c2 <= '{default: '0};
			m_a1c2 <= '{default: '0};
			m_a2c1 <= '{default: '0};
			m_b1s1 <= '{default: '0};
			m_b2s2 <= '{default: '0};
			m_b1s2 <= '{default: '0};
			m_b2s1 <= '{default: '0};
			y0 <= '{default: '0};
			t1 <= '{default: '0};
			t2 <= '{default: '0};
			u1 <= '{default: '0};
			u2 <= '{default: '0};
		end else begin
			for (int c = 0; c < 2; c++) begin
				x0_s1[c] <= x_q[0][c];
				a1[c] <= x_q[1][c] + x_q[4][c];
				b1[c] <= x_q[1][c] - x_q[4][c];
				a2[c] <= x_q[2][c] + x_q[3][c];
				b2[c] <= x_q[2][c] - x_q[3][c];

				x0_s2[c] <= x0_s1[c];
				t0[c] <= a1[c] + a2[c];
				m_a1c1[c] <= mul_rnd(a1[c], `MRD_C1);
				m_a2c2[c] <= mul_rnd(a2[c], `MRD_C2);
				m_a1c2[c] <= mul_rnd(a1[c], `MRD_C2);
				m_a2c1[c] <= mul_rnd(a2[c], `MRD_C1);
				m_b1s1[c] <= mul_rnd(b1[c], `MRD_S1);
				m_b2s2[c] <= mul_rnd(b2[c], `MRD_S2);
				m_b1s2[c] <= mul_rnd(b1[c], `MRD_S2);
				m_b2s1[c] <= mul_rnd(b2[c], `MRD_S1);

				x0_s3[c] <= x0_s2[c];
				y0[c] <= x0_s2[c] + t0[c];
				t1[c] <= m_a1c1[c] + m_a2c2[c];
				t2[c] <= m_a1c2[c] + m_a2c1[c];
				u1[c] <= m_b1s1[c] + m_b2s2[c];
				u2[c] <= m_b1s2[c] - m_b2s1[c];
			end
		end
	end

	// X1 and X4 share t1 and u1 while X2 and X3 share t2 and u2
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sum_re <= '{default: '0};
			sum_im <= '{default: '0};
		end else begin
			sum_re[0] <= y0[RE];
			sum_im[0] <= y0[IM];
			sum_re[1] <= x0_s3[RE] + t1[RE] + u1[IM];
			sum_im[1] <= x0_s3[IM] + t1[IM] - u1[RE];
			sum_re[4] <= x0_s3[RE] + t1[RE] - u1[IM];
			sum_im[4] <= x0_s3[IM] + t1[IM] + u1[RE];
			sum_re[2] <= x0_s3[RE] + t2[RE] + u2[IM];
			sum_im[2] <= x0_s3[IM] + t2[IM] - u2[RE];
			sum_re[3] <= x0_s3[RE] + t2[RE] - u2[IM];
			sum_im[3] <= x0_s3[IM] + t2[IM] + u2[RE];
		end
	end

	for (genvar n = 0; n < `MRD_LANES; n++) begin : g_round
		mrd_bfp_round round_re_i (.clk, .rst_n, .x_i(sum_re[n]), .growth_i(word_growth_i),
			.y_o(dout_re_o[n]));
		mrd_bfp_round round_im_i (.clk, .rst_n, .x_i(sum_im[n]), .growth_i(word_growth_i),
			.y_o(dout_im_o[n]));
	end

endmodule

// File: src/mrd_out_select.sv
`timescale 1ns/1ps
`include "mrd_consts.svh"

module mrd_out_select (
	input logic clk,
	input logic rst_n,
	input mrd_cfg_pkg::radix_e radix_i,
	input mrd_cfg_pkg::growth_t word_growth_i,
	input logic val_i,
	input mrd_cfg_pkg::exp_t exp_i,
	input mrd_data_pkg::sample_t r42_re_i [0:`MRD_LANES-1],
	input mrd_data_pkg::sample_t r42_im_i [0:`MRD_LANES-1],
	input mrd_data_pkg::sample_t r5_re_i [0:`MRD_LANES-1],
	input mrd_data_pkg::sample_t r5_im_i [0:`MRD_LANES-1],
	output logic out_val_o,
	output mrd_cfg_pkg::exp_t exp_o,
	output mrd_data_pkg::sample_t dout_re_o [0:`MRD_LANES-1],
	output mrd_data_pkg::sample_t dout_im_o [0:`MRD_LANES-1]
);
	import mrd_cfg_pkg::*;

	logic use_r5;

	assign use_r5 = (radix_i == RADIX_5);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_val_o <= 1'b0;
			exp_o <= '0;
			dout_re_o <= '{default: '0};
			dout_im_o <= '{default: '0};
		end else begin
			out_val_o <= val_i;
			// exponent only moves with a valid vector
			if (val_i) begin
				exp_o <= exp_i + exp_t'(word_growth_i);
			end
			for (int i = 0; i < `MRD_LANES; i++) begin
				dout_re_o[i] <= use_r5 ? r5_re_i[i] : r42_re_i[i];
				dout_im_o[i] <= use_r5 ? r5_im_i[i] : r42_im_i[i];
			end
		end
	end

endmodule

// File: src/mrd_stage_top.sv
`timescale 1ns/1ps
`include "mrd_consts.svh"

module mrd_stage_top (
	input logic clk,
	input logic rst_n,
	input logic cfg_we_i,
	input mrd_cfg_pkg::radix_e factor_i,
	input mrd_cfg_pkg::margin_t margin_i,
	input logic in_val_i,
	input mrd_cfg_pkg::exp_t exp_i,
	input mrd_data_pkg::sample_t din_re_i [0:`MRD_LANES-1],
	input mrd_data_pkg::sample_t din_im_i [0:`MRD_LANES-1],
	output logic out_val_o,
	output mrd_cfg_pkg::exp_t exp_o,
	output mrd_data_pkg::sample_t dout_re_o [0:`MRD_LANES-1],
	output mrd_data_pkg::sample_t dout_im_o [0:`MRD_LANES-1]
);
	import mrd_data_pkg::*;
	import mrd_cfg_pkg::*;

	radix_e radix;
	growth_t word_growth;
	logic val_dly;
	exp_t exp_dly;
	sample_t r42_re [0:`MRD_LANES-1];
	sample_t r42_im [0:`MRD_LANES-1];
	sample_t r5_re [0:`MRD_LANES-1];
	sample_t r5_im [0:`MRD_LANES-1];

	mrd_stage_cfg cfg_i (.clk, .rst_n, .cfg_we_i, .factor_i, .margin_i,
		.radix_o(radix), .word_growth_o(word_growth));

	// valid and exponent wait for the engine results
	mrd_align_delay #(.T(logic), .DEPTH(`MRD_ENG_LAT)) val_dly_i (
		.clk, .rst_n, .d_i(in_val_i), .q_o(val_dly)
	);
	mrd_align_delay #(.T(exp_t), .DEPTH(`MRD_ENG_LAT)) exp_dly_i (
		.clk, .rst_n, .d_i(exp_i), .q_o(exp_dly)
	);

	mrd_rdx4_2 rdx4_2_i (.clk, .rst_n, .radix_i(radix), .word_growth_i(word_growth),
		.din_re_i, .din_im_i, .dout_re_o(r42_re), .dout_im_o(r42_im));

	mrd_rdx5 rdx5_i (.clk, .rst_n, .radix_i(radix), .word_growth_i(word_growth),
		.din_re_i, .din_im_i, .dout_re_o(r5_re), .dout_im_o(r5_im));

	mrd_out_select out_sel_i (.clk, .rst_n, .radix_i(radix), .word_growth_i(word_growth),
		.val_i(val_dly), .exp_i(exp_dly),
		.r42_re_i(r42_re), .r42_im_i(r42_im), .r5_re_i(r5_re), .r5_im_i(r5_im),
		.out_val_o, .exp_o, .dout_re_o, .dout_im_o);

endmodule

// File: testbench/mrd_stage_tb.sv
`timescale 1ns/1ps
`include "mrd_consts.svh"

module mrd_stage_tb;
	import mrd_data_pkg::*;
	import mrd_cfg_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int RST_CYCLES = 5;
	localparam int LANES = `MRD_LANES;
	localparam real PI = 3.14159265358979;
	// slots per test with about a quarter of them idle
	localparam int R4_SLOTS = 64;
	localparam int R4M_SLOTS = 32;
	localparam int R2_SLOTS = 24;
	localparam int R5_SLOTS = 64;
	localparam int R5M_SLOTS = 24;
	localparam int N_TESTS = 8;
	localparam int RUN_CYCLES = RST_CYCLES + 3 + R4_SLOTS + R4M_SLOTS + 4 * R2_SLOTS
		+ R5_SLOTS + R5M_SLOTS + 20 * N_TESTS;

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	logic cfg_we_i = 1'b0;
	radix_e factor_i = RADIX_4;
	margin_t margin_i = '0;
	logic in_val_i = 1'b0;
	exp_t exp_i = '0;
	sample_t din_re_i [0:LANES-1];
	sample_t din_im_i [0:LANES-1];
	logic out_val_o;
	exp_t exp_o;
	sample_t dout_re_o [0:LANES-1];
	sample_t dout_im_o [0:LANES-1];

	integer seed;
	string test_name = "reset";
	int cur_tol = 0;
	logic reset_chk = 1'b1;
	logic [7:0] val_hist = '0;
	exp_t exp_hold = '0;
	int vec_re [LANES];
	int vec_im [LANES];
	int ref_re [LANES];
	int ref_im [LANES];
	// reference results in input order
	int want_re_q [$];
	int want_im_q [$];
	int want_e_q [$];
	int err_reset = 0;
	int err_valid = 0;
	int err_exp = 0;
	int err_data = 0;
	int err_other = 0;

	mrd_stage_top mrd_stage_top_i (.clk, .rst_n, .cfg_we_i, .factor_i, .margin_i, .in_val_i,
		.exp_i, .din_re_i, .din_im_i, .out_val_o, .exp_o, .dout_re_o, .dout_im_o);

	initial begin
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// signed value with margin bits of headroom
	function automatic int rand_sample(input int margin);
		int r;
		r = $random(seed);
		return r >>> (14 + margin);
	endfunction

	// floor(x / 2^growth + 1/2)
	function automatic int scale_round(input real x, input int growth);
		return $rtoi($floor(x / (2.0 ** growth) + 0.5));
	endfunction

	// e^(-j 2 pi m / npts) with exact quarter turns
	task automatic twiddle(input int npts, input int m, output real wr, output real wi);
		int q;
		if (npts == 5) begin
			wr = $cos(2.0 * PI * m / 5.0);
			wi = -$sin(2.0 * PI * m / 5.0);
		end else begin
			q = (4 * m / npts) % 4;
			wr = (q == 0) ? 1.0 : ((q == 2) ? -1.0 : 0.0);
			wi = (q == 1) ? -1.0 : ((q == 3) ? 1.0 : 0.0);
		end
	endtask

	// direct DFT over lanes base to base+npts-1
	task automatic dft_ref(input int npts, input int base, input int growth);
		real acc_re;
		real acc_im;
		real wr;
		real wi;
		for (int k = 0; k < npts; k++) begin
			acc_re = 0.0;
			acc_im = 0.0;
			for (int n = 0; n < npts; n++) begin
				twiddle(npts, (k * n) % npts, wr, wi);
				acc_re += vec_re[base+n] * wr - vec_im[base+n] * wi;
				acc_im += vec_re[base+n] * wi + vec_im[base+n] * wr;
			end
			ref_re[base+k] = scale_round(acc_re, growth);
			ref_im[base+k] = scale_round(acc_im, growth);
		end
	endtask

	task automatic push_expected(input radix_e radix, input int growth, input int e);
		for (int l = 0; l < LANES; l++) begin
			ref_re[l] = 0;
			ref_im[l] = 0;
		end
		if (radix == RADIX_2) begin
			dft_ref(2, 0, growth);
			dft_ref(2, 2, growth);
		end else if (radix == RADIX_4) begin
			dft_ref(4, 0, growth);
		end else begin
			dft_ref(5, 0, growth);
		end
		for (int l = 0; l < LANES; l++) begin
			want_re_q.push_back(ref_re[l]);
			want_im_q.push_back(ref_im[l]);
		end
		want_e_q.push_back((e + growth) % 16);
	endtask

	// one input slot that is valid or idle
	task automatic drive_slot(input radix_e radix, input int margin, input int growth);
		logic valid;
		int e;
		valid = (($random(seed) & 3) != 0);
		e = $random(seed) & 15;
		for (int l = 0; l < LANES; l++) begin
			vec_re[l] = rand_sample(margin);
			vec_im[l] = rand_sample(margin);
			din_re_i[l] <= sample_t'(vec_re[l]);
			din_im_i[l] <= sample_t'(vec_im[l]);
		end
		in_val_i <= valid;
		exp_i <= exp_t'(e);
		if (valid) begin
			push_expected(radix, growth, e);
		end
	endtask

	task automatic run_test(input string name, input radix_e radix, input int margin,
		input int slots);
		int growth;
		growth = (radix == RADIX_2) ? 2 : 3;
		growth = (growth > margin) ? growth - margin : 0;
		test_name = name;
		cur_tol = (radix == RADIX_5) ? 4 : 0;
		cfg_we_i <= 1'b1;
		factor_i <= radix;
		margin_i <= margin_t'(margin);
		@(posedge clk);
		cfg_we_i <= 1'b0;
		@(posedge clk);
		for (int s = 0; s < slots; s++) begin
			drive_slot(radix, margin, growth);
			@(posedge clk);
		end
		in_val_i <= 1'b0;
		// pipeline must be empty before the next configuration
		while (want_e_q.size() != 0) begin
			@(posedge clk);
		end
	endtask

	task automatic report_value(input string what, input int expected, input int actual);
		$display("ERROR %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
	endtask

	task automatic compare_sample(input string what, input int want, input int got);
		int diff;
		diff = (got > want) ? got - want : want - got;
		assert (diff <= cur_tol) else begin
			report_value(what, want, got);
			err_data++;
		end
	endtask

	task automatic check_lanes();
		for (int l = 0; l < LANES; l++) begin
			compare_sample($sformatf("lane %0d re", l), want_re_q.pop_front(), dout_re_o[l]);
			compare_sample($sformatf("lane %0d im", l), want_im_q.pop_front(), dout_im_o[l]);
		end
	endtask

	task automatic check_zero_outputs();
		assert (out_val_o == 1'b0) else begin
			report_value("out_val_o", 0, out_val_o);
			err_reset++;
		end
		assert (exp_o == '0) else begin
			report_value("exp_o", 0, exp_o);
			err_reset++;
		end
		for (int l = 0; l < LANES; l++) begin
			assert (dout_re_o[l] == '0) else begin
				report_value($sformatf("lane %0d re", l), 0, dout_re_o[l]);
				err_reset++;
			end
			assert (dout_im_o[l] == '0) else begin
				report_value($sformatf("lane %0d im", l), 0, dout_im_o[l]);
				err_reset++;
			end
		end
	endtask

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		if (reset_chk) begin
			check_zero_outputs();
		end
		if (!rst_n) begin
			val_hist = '0;
			exp_hold = '0;
		end else begin
			// bit 7 is in_val_i seven cycles back
			val_hist = {val_hist[6:0], in_val_i};
			assert (out_val_o == val_hist[7]) else begin
				report_value("out_val_o", val_hist[7], out_val_o);
				err_valid++;
			end
			if (val_hist[7]) begin
				if (want_e_q.size() == 0) begin
					$display("output vector in test %s has no reference vector", test_name);
					err_other++;
				end else begin
					exp_hold = exp_t'(want_e_q.pop_front());
					check_lanes();
				end
			end
			assert (exp_o == exp_hold) else begin
				report_value("exp_o", exp_hold, exp_o);
				err_exp++;
			end
		end
	end

	initial begin
		int total;
		seed = 32'hdf3c5466;
		for (int l = 0; l < LANES; l++) begin
			din_re_i[l] = '0;
			din_im_i[l] = '0;
		end
		repeat (RST_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		repeat (3) @(posedge clk);
		reset_chk <= 1'b0;
		run_test("radix4 margin 0", RADIX_4, 0, R4_SLOTS);
		run_test("radix4 margin 2", RADIX_4, 2, R4M_SLOTS);
		for (int m = 0; m < 4; m++) begin
			run_test($sformatf("radix2 margin %0d", m), RADIX_2, m, R2_SLOTS);
		end
		run_test("radix5 margin 0", RADIX_5, 0, R5_SLOTS);
		run_test("radix5 margin 1", RADIX_5, 1, R5M_SLOTS);
		total = err_reset + err_valid + err_exp + err_data + err_other;
		$display("errors: reset %0d, valid %0d, exponent %0d, data %0d, other %0d",
			err_reset, err_valid, err_exp, err_data, err_other);
		if (total == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	initial begin
		#(RUN_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles in test %s", RUN_CYCLES, test_name);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: mrd_stage.f
+incdir+include
src/mrd_data_pkg.sv
src/mrd_cfg_pkg.sv
src/mrd_align_delay.sv
src/mrd_bfp_round.sv
src/mrd_stage_cfg.sv
src/mrd_rdx4_2.sv
src/mrd_rdx5.sv
src/mrd_out_select.sv
src/mrd_stage_top.sv
testbench/mrd_stage_tb.sv
